// ==== src/sa_pkg.sv ====
// systolic array shared types

package sa_pkg;

    // default array size, also the number of beats per matrix
    parameter int ARRAY_DIM = 4;

    // element and partial-sum widths
    parameter int DATA_W = 8;
    parameter int PSUM_W = 32;

    // signed operand element
    typedef logic signed [DATA_W-1:0] data_t;

    // signed partial sum, wide enough for the full dot product
    typedef logic signed [PSUM_W-1:0] psum_t;

    // one matrix row, element 0 in the low bits
    typedef logic [ARRAY_DIM*DATA_W-1:0] slice_t;

endpackage

// ==== src/sync_fifo.sv ====
// small synchronous FIFO
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic s_clk,
    input  logic s_rst,
    input  logic i_wr_en,
    input  T     i_wr_data,
    input  logic i_rd_en,
    output T     o_rd_data,
    output logic o_empty,
    output logic o_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T               mem [DEPTH];
    logic [AW-1:0]  wr_idx;
    logic [AW-1:0]  rd_idx;
    logic [AW:0]    count;
    logic           do_rd;
    logic           do_wr;

    function automatic logic [AW-1:0] next_idx(input logic [AW-1:0] idx);
        next_idx = (idx == AW'(DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign o_empty   = (count == '0);
    assign o_full    = (count == (AW+1)'(DEPTH));
    assign o_rd_data = mem[rd_idx];

    // a write into a full FIFO is fine when the head leaves in the same cycle
    assign do_rd = i_rd_en && !o_empty;
    assign do_wr = i_wr_en && (!o_full || do_rd);

    always_ff @(posedge s_clk) begin
        if (do_wr) begin
            mem[wr_idx] <= i_wr_data;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_idx <= next_idx(wr_idx);
            end
            if (do_rd) begin
                rd_idx <= next_idx(rd_idx);
            end
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

endmodule

// ==== src/systolic_pe.sv ====
// systolic MAC cell
`timescale 1ns/1ps

module systolic_pe import sa_pkg::*; (
    input  logic  s_clk,
    input  logic  s_rst,
    input  data_t i_weight,
    input  data_t i_act,
    input  logic  i_act_valid,
    input  psum_t i_psum_in,
    output data_t o_act,
    output logic  o_act_valid,
    output psum_t o_psum,
    output logic  o_psum_valid
);

    logic signed [2*DATA_W-1:0] prod;

    assign prod = i_weight * i_act;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_act_valid  <= 1'b0;
            o_psum_valid <= 1'b0;
        end else begin
            o_act_valid  <= i_act_valid;
            o_psum_valid <= i_act_valid;
        end
    end

    // activation moves right, psum moves down
    always_ff @(posedge s_clk) begin
        o_act <= i_act;
        if (i_act_valid) begin
            o_psum <= i_psum_in + psum_t'(prod);
        end
    end

endmodule

// ==== src/pe_array.sv ====
// PE grid
`timescale 1ns/1ps

module pe_array import sa_pkg::*; #(
    parameter int N = ARRAY_DIM
) (
    input  logic         s_clk,
    input  logic         s_rst,
    input  data_t        i_weights [N][N],
    input  data_t        i_row_act [N],
    input  logic [N-1:0] i_row_valid,
    output psum_t        o_col_psum [N],
    output logic [N-1:0] o_col_valid
);

    // horizontal activation links, column N is the unused right edge
    data_t act_w  [N][N+1];
    logic  act_v  [N][N+1];

    // vertical psum links, row 0 is the zero feed on top
    psum_t psum_w [N+1][N];
    logic  psum_v [N][N];

    for (genvar k = 0; k < N; k++) begin : g_row
        assign act_w[k][0] = i_row_act[k];
        assign act_v[k][0] = i_row_valid[k];

        for (genvar j = 0; j < N; j++) begin : g_col
            systolic_pe u_pe (
                .s_clk        (s_clk),
                .s_rst        (s_rst),
                .i_weight     (i_weights[k][j]),
                .i_act        (act_w[k][j]),
                .i_act_valid  (act_v[k][j]),
                .i_psum_in    (psum_w[k][j]),
                .o_act        (act_w[k][j+1]),
                .o_act_valid  (act_v[k][j+1]),
                .o_psum       (psum_w[k+1][j]),
                .o_psum_valid (psum_v[k][j])
            );
        end
    end

    for (genvar j = 0; j < N; j++) begin : g_edge
        assign psum_w[0][j]   = '0;
        // bottom row carries the finished dot products
        assign o_col_psum[j]  = psum_w[N][j];
        assign o_col_valid[j] = psum_v[N-1][j];
    end

endmodule

// ==== src/weight_loader.sv ====
// stationary weight loader
`timescale 1ns/1ps

module weight_loader import sa_pkg::*; #(
    parameter int N = ARRAY_DIM
) (
    input  logic   s_clk,
    input  logic   s_rst,
    input  logic   i_b_valid,
    input  slice_t i_b_data,
    input  logic   i_done,
    output logic   o_b_ready,
    output logic   o_loaded,
    output data_t  o_weights [N][N]
);

    localparam int CW = (N > 1) ? $clog2(N) : 1;

    logic [CW-1:0] beat_cnt;
    logic          b_fire;

    // intake closes once B is complete
    assign o_b_ready = !o_loaded;
    assign b_fire    = i_b_valid && o_b_ready;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            beat_cnt <= '0;
            o_loaded <= 1'b0;
        end else if (i_done) begin
            beat_cnt <= '0;
            o_loaded <= 1'b0;
        end else if (b_fire) begin
            if (beat_cnt == CW'(N - 1)) begin
                beat_cnt <= '0;
                o_loaded <= 1'b1;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // beat k is row k of B
    always_ff @(posedge s_clk) begin
        if (b_fire) begin
            for (int j = 0; j < N; j++) begin
                o_weights[beat_cnt][j] <= data_t'(i_b_data[j*DATA_W +: DATA_W]);
            end
        end
    end

endmodule

// ==== src/act_feeder.sv ====
// skewed activation feeder
`timescale 1ns/1ps

module act_feeder import sa_pkg::*; #(
    parameter int N = ARRAY_DIM
) (
    input  logic         s_clk,
    input  logic         s_rst,
    input  logic         i_a_valid,
    input  slice_t       i_a_data,
    input  logic         i_loaded,
    input  logic         i_done,
    output logic         o_a_ready,
    output data_t        o_row_act [N],
    output logic [N-1:0] o_row_valid
);

    localparam int CW = (N > 1) ? $clog2(N) : 1;

    logic [CW-1:0] a_cnt;
    logic [CW-1:0] rd_cnt;
    logic          a_full;
    logic          busy;
    logic          a_fire;
    logic          start;
    logic [N-1:0]  rd_chain;
    logic [N-1:0]  lane_empty;

    assign o_a_ready = !a_full;
    assign a_fire    = i_a_valid && o_a_ready;
    assign start     = a_full && i_loaded && !busy;

    // A beat counter, intake stays closed until the tile is done
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            a_cnt  <= '0;
            a_full <= 1'b0;
        end else if (i_done) begin
            a_cnt  <= '0;
            a_full <= 1'b0;
        end else if (a_fire) begin
            if (a_cnt == CW'(N - 1)) begin
                a_cnt  <= '0;
                a_full <= 1'b1;
            end else begin
                a_cnt <= a_cnt + 1'b1;
            end
        end
    end

    // lane 0 reads for N cycles, each next lane one cycle later
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            busy     <= 1'b0;
            rd_cnt   <= '0;
            rd_chain <= '0;
        end else begin
            if (i_done) begin
                busy <= 1'b0;
            end else if (start) begin
                busy <= 1'b1;
            end
            if (start) begin
                rd_chain[0] <= 1'b1;
                rd_cnt      <= '0;
            end else if (rd_chain[0]) begin
                if (rd_cnt == CW'(N - 1)) begin
                    rd_chain[0] <= 1'b0;
                end
                rd_cnt <= rd_cnt + 1'b1;
            end
            rd_chain[N-1:1] <= rd_chain[N-2:0];
        end
    end

    for (genvar k = 0; k < N; k++) begin : g_lane
        sync_fifo #(
            .T     (data_t),
            .DEPTH (N)
        ) u_lane (
            .s_clk     (s_clk),
            .s_rst     (s_rst),
            .i_wr_en   (a_fire),
            .i_wr_data (data_t'(i_a_data[k*DATA_W +: DATA_W])),
            .i_rd_en   (rd_chain[k]),
            .o_rd_data (o_row_act[k]),
            .o_empty   (lane_empty[k]),
            .o_full    ()
        );

        assign o_row_valid[k] = rd_chain[k] && !lane_empty[k];
    end

endmodule

// ==== src/psum_accum.sv ====
// psum queues and accumulation
`timescale 1ns/1ps

module psum_accum import sa_pkg::*; #(
    parameter int N = ARRAY_DIM
) (
    input  logic                  s_clk,
    input  logic                  s_rst,
    input  logic                  i_init,
    input  psum_t                 i_col_psum [N],
    input  logic [N-1:0]          i_col_valid,
    input  logic                  i_rd_en,
    input  logic [$clog2(N)-1:0]  i_rd_col,
    output logic                  o_done,
    output psum_t                 o_rd_data
);

    localparam int CW = (N > 1) ? $clog2(N) : 1;

    logic          acc_flag;
    logic [CW-1:0] wr_cnt;
    logic [N-1:0]  q_pop;
    psum_t         head    [N];
    psum_t         wr_data [N];

    for (genvar j = 0; j < N; j++) begin : g_queue
        // when accumulating, the old value leaves and the sum goes back in
        assign wr_data[j] = acc_flag ? head[j] + i_col_psum[j] : i_col_psum[j];
        assign q_pop[j]   = (acc_flag && i_col_valid[j])
                          || (i_rd_en && (i_rd_col == $clog2(N)'(j)));

        sync_fifo #(
            .T     (psum_t),
            .DEPTH (N)
        ) u_queue (
            .s_clk     (s_clk),
            .s_rst     (s_rst),
            .i_wr_en   (i_col_valid[j]),
            .i_wr_data (wr_data[j]),
            .i_rd_en   (q_pop[j]),
            .o_rd_data (head[j]),
            .o_empty   (),
            .o_full    ()
        );
    end

    // selected column head goes straight out
    assign o_rd_data = head[i_rd_col];

    // the last column finishes last and its N-th result ends the tile
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_cnt   <= '0;
            o_done   <= 1'b0;
            acc_flag <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_col_valid[N-1]) begin
                if (wr_cnt == CW'(N - 1)) begin
                    wr_cnt <= '0;
                    o_done <= 1'b1;
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
            if (i_init) begin
                acc_flag <= 1'b0;
            end else if (o_done) begin
                acc_flag <= 1'b1;
            end
        end
    end

endmodule

// ==== src/systolic_top.sv ====
// weight-stationary systolic matrix multiplier
`timescale 1ns/1ps

module systolic_top import sa_pkg::*; #(
    parameter int N = ARRAY_DIM
) (
    input  logic                  s_clk,
    input  logic                  s_rst,
    input  logic                  i_init,
    input  logic                  i_b_valid,
    input  slice_t                i_b_data,
    output logic                  o_b_ready,
    input  logic                  i_a_valid,
    input  slice_t                i_a_data,
    output logic                  o_a_ready,
    output logic                  o_done,
    input  logic                  i_rd_en,
    input  logic [$clog2(N)-1:0]  i_rd_col,
    output psum_t                 o_rd_data
);

    data_t        weights   [N][N];
    data_t        row_act   [N];
    psum_t        col_psum  [N];
    logic [N-1:0] row_valid;
    logic [N-1:0] col_valid;
    logic         loaded;

    weight_loader #(.N(N)) u_weight_loader (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .i_b_valid (i_b_valid),
        .i_b_data  (i_b_data),
        .i_done    (o_done),
        .o_b_ready (o_b_ready),
        .o_loaded  (loaded),
        .o_weights (weights)
    );

    act_feeder #(.N(N)) u_act_feeder (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_a_valid   (i_a_valid),
        .i_a_data    (i_a_data),
        .i_loaded    (loaded),
        .i_done      (o_done),
        .o_a_ready   (o_a_ready),
        .o_row_act   (row_act),
        .o_row_valid (row_valid)
    );

    pe_array #(.N(N)) u_pe_array (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_weights   (weights),
        .i_row_act   (row_act),
        .i_row_valid (row_valid),
        .o_col_psum  (col_psum),
        .o_col_valid (col_valid)
    );

    psum_accum #(.N(N)) u_psum_accum (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_init      (i_init),
        .i_col_psum  (col_psum),
        .i_col_valid (col_valid),
        .i_rd_en     (i_rd_en),
        .i_rd_col    (i_rd_col),
        .o_done      (o_done),
        .o_rd_data   (o_rd_data)
    );

endmodule

// ==== tb/tb_systolic.sv ====
// systolic multiplier testbench
`timescale 1ns/1ps

module tb_systolic import sa_pkg::*; ();

    localparam int N               = ARRAY_DIM;
    localparam int CW              = $clog2(N);
    localparam int CYCLES_PER_TILE = 80;
    localparam int TIMEOUT_MARGIN  = 200;
    localparam int GOLDEN_WORDS    = 256;

    logic          s_clk;
    logic          s_rst;
    logic          i_init;
    logic          i_b_valid;
    slice_t        i_b_data;
    logic          o_b_ready;
    logic          i_a_valid;
    slice_t        i_a_data;
    logic          o_a_ready;
    logic          o_done;
    logic          i_rd_en;
    logic [CW-1:0] i_rd_col;
    psum_t         o_rd_data;

    logic [31:0] golden [GOLDEN_WORDS];
    integer      seed;
    int          gap_b [$];
    int          gap_a [$];
    int          cycle_count;
    int          cycle_limit;
    int          done_count;

    systolic_top #(.N(N)) u_systolic_top (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .i_init    (i_init),
        .i_b_valid (i_b_valid),
        .i_b_data  (i_b_data),
        .o_b_ready (o_b_ready),
        .i_a_valid (i_a_valid),
        .i_a_data  (i_a_data),
        .o_a_ready (o_a_ready),
        .o_done    (o_done),
        .i_rd_en   (i_rd_en),
        .i_rd_col  (i_rd_col),
        .o_rd_data (o_rd_data)
    );

    initial s_clk = 1'b0;
    always #4 s_clk = ~s_clk;

    // o_done is one cycle wide, so one negedge sees each pulse
    always @(negedge s_clk) begin
        if (s_rst) begin
            done_count <= 0;
        end else if (o_done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge s_clk) begin
        if (s_rst) begin
            cycle_count <= 0;
        end else if (cycle_count >= cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $fatal(1, "run timed out");
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // one intake, all tiles of a test; the next tile is offered early
    task automatic send_operand(input bit is_a, input int first, input int ntiles,
                                input int done_base);
        logic [31:0] word;
        int          gap;
        string       what;
        what = is_a ? "A beat accepted before done" : "B beat accepted before done";
        for (int t = 0; t < ntiles; t++) begin
            for (int k = 0; k < N; k++) begin
                word = golden[first + t*2*N + (is_a ? N : 0) + k];
                gap  = is_a ? gap_a[t*N + k] : gap_b[t*N + k];
                repeat (gap) begin
                    @(posedge s_clk);
                    if (is_a) i_a_valid <= 1'b0;
                    else      i_b_valid <= 1'b0;
                end
                @(posedge s_clk);
                if (is_a) begin
                    i_a_valid <= 1'b1;
                    i_a_data  <= word;
                end else begin
                    i_b_valid <= 1'b1;
                    i_b_data  <= word;
                end
                @(negedge s_clk);
                while (!(is_a ? o_a_ready : o_b_ready)) begin
                    @(negedge s_clk);
                end
                // beat transfers at the coming edge, tile t needs t earlier dones
                check_value(done_count - done_base, t, what);
            end
        end
        @(posedge s_clk);
        if (is_a) i_a_valid <= 1'b0;
        else      i_b_valid <= 1'b0;
    endtask

    task automatic wait_tiles(input int target);
        while (done_count < target) begin
            @(negedge s_clk);
        end
    endtask

    // columns in turn, rows in order
    task automatic read_results(input int first);
        for (int c = 0; c < N; c++) begin
            for (int r = 0; r < N; r++) begin
                @(posedge s_clk);
                i_rd_en  <= 1'b1;
                i_rd_col <= CW'(c);
                @(negedge s_clk);
                check_value(o_rd_data, golden[first + c*N + r],
                            $sformatf("psum column %0d row %0d", c, r));
            end
        end
        @(posedge s_clk);
        i_rd_en <= 1'b0;
    endtask

    initial begin
        int ptr;
        int ntests;
        int init_flag;
        int ntiles;
        int total_tiles;
        int done_base;
        s_rst     = 1'b1;
        i_init    = 1'b0;
        i_b_valid = 1'b0;
        i_b_data  = '0;
        i_a_valid = 1'b0;
        i_a_data  = '0;
        i_rd_en   = 1'b0;
        i_rd_col  = '0;
        seed      = 95;
        $readmemh("tb/golden_tiles.mem", golden);
        ntests      = golden[0];
        ptr         = 1;
        total_tiles = 0;
        for (int tn = 0; tn < ntests; tn++) begin
            ntiles       = golden[ptr + 1];
            total_tiles += ntiles;
            ptr         += 2 + ntiles*2*N + N*N;
        end
        cycle_limit = CYCLES_PER_TILE*total_tiles + TIMEOUT_MARGIN;
        repeat (2) @(posedge s_clk);
        s_rst <= 1'b0;
        ptr = 1;
        for (int tn = 0; tn < ntests; tn++) begin
            init_flag = golden[ptr];
            ntiles    = golden[ptr + 1];
            ptr      += 2;
            if (init_flag != 0) begin
                @(posedge s_clk);
                i_init <= 1'b1;
                @(posedge s_clk);
                i_init <= 1'b0;
            end
            gap_b.delete();
            gap_a.delete();
            for (int i = 0; i < ntiles*N; i++) begin
                gap_b.push_back($random(seed) & 3);
                gap_a.push_back($random(seed) & 3);
            end
            done_base = done_count;
            fork
                send_operand(1'b0, ptr, ntiles, done_base);
                send_operand(1'b1, ptr, ntiles, done_base);
                wait_tiles(done_base + ntiles);
            join
            ptr += ntiles*2*N;
            repeat (8) @(posedge s_clk);
            check_value(done_count - done_base, ntiles, "done pulses per test");
            read_results(ptr);
            ptr += N*N;
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== tb/golden_tiles.mem ====
// per test: init flag, tile count, then per tile 4 B rows and 4 A rows as packed slices
// then 16 expected psums, column 0 rows 0..3 first; element 0 sits in the low byte
4
// single tile
1 1
04030201 02ff0100 fd010002 010003ff
ff020001 02000103 000104fe 0503ff00
00000006 00000001 00000000 00000001 ffffffff 0000000d 00000000 0000000e
00000005 00000008 fffffff7 00000004 fffffffd 00000010 fffffffd fffffffa
// three tiles accumulated: A with B=I, A with B=2I, A=I with B
1 3
00000001 00000100 00010000 01000000
04030201 08070605 fcfdfeff 281e140a
00000002 00000200 00020000 02000000
01010101 00000000 fe02fe02 640500fb
01f90003 ffffffff 09000900 fa06807f
00000001 00000100 00010000 01000000
00000006 00000004 00000003 0000007f 00000004 00000005 00000003 ffffff94
fffffffe 00000006 00000001 0000002e 00000007 00000007 00000001 000000ea
// new sequence after init, B all ones gives row sums of A
1 1
01010101 01010101 01010101 01010101
04030201 08070605 fcfdfeff 281e140a
0000000a 0000001a fffffff6 00000064 0000000a 0000001a fffffff6 00000064
0000000a 0000001a fffffff6 00000064 0000000a 0000001a fffffff6 00000064
// extreme operands, A all -128 against -128, 127 and -1 weights
1 1
ff807f80 ff7f7f80 ff807f80 ff7f7f80
80808080 80808080 80808080 80808080
00010000 00010000 00010000 00010000 ffff0200 ffff0200 ffff0200 ffff0200
00000100 00000100 00000100 00000100 00000200 00000200 00000200 00000200

// ==== tb.f ====
src/sa_pkg.sv
src/sync_fifo.sv
src/systolic_pe.sv
src/pe_array.sv
src/weight_loader.sv
src/act_feeder.sv
src/psum_accum.sv
src/systolic_top.sv
tb/tb_systolic.sv

// ==== Makefile ====
TOP := tb_systolic

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f -o vsim
	./obj_dir/vsim

clean:
	rm -rf obj_dir

.PHONY: sim clean
